// File: include/rbk_rf_defines.svh
`ifndef RBK_RF_DEFINES_SVH
`define RBK_RF_DEFINES_SVH

// data path
`define RBK_DATA_W      512
`define RBK_ADDR_W      5
`define RBK_MASK_W      12
`define RBK_ATOM_BYTES  32

// command fields and counters
`define RBK_CNT_W       6
`define RBK_WCMD_W      11
`define RBK_RCMD_W      12

// two slots plus wrap bit
`define RBK_SLOT_PTR_W  2

`endif

// File: source/rbk_rf_pkg.sv
`default_nettype none

`include "rbk_rf_defines.svh"

package rbk_rf_pkg;

  // value 1 (split) is reserved
  typedef enum logic [1:0] {
    rbk_mode_contract = 2'd0,
    rbk_mode_merge    = 2'd2
  } rbk_mode_e;

  typedef enum logic [1:0] {
    rbk_prec_int8  = 2'd0,
    rbk_prec_int16 = 2'd1
  } rbk_prec_e;

  typedef struct packed {
    logic [`RBK_WCMD_W-`RBK_CNT_W-1:0] row_m1;  // rows - 1
    logic [`RBK_CNT_W-1:0]             col_m1;  // columns - 1
  } rbk_wr_cmd_t;

  typedef struct packed {
    logic [`RBK_CNT_W-1:0] row_m1;
    logic [`RBK_CNT_W-1:0] col_m1;
  } rbk_rd_cmd_t;

  typedef struct packed {
    logic [`RBK_ADDR_W-1:0] addr;
    logic [`RBK_DATA_W-1:0] data;
    logic                   done;  // last beat of a write command
  } rbk_rf_wr_t;

  typedef struct packed {
    logic [`RBK_ADDR_W-1:0] addr;
    logic [`RBK_MASK_W-1:0] mask;  // {atom1 bytes, atom0 bytes}
    logic                   done;
  } rbk_rf_rd_t;

endpackage

`default_nettype wire

// File: source/rbk_cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module rbk_cmd_fifo #(
  parameter int width = 11
) (
  input  logic             nvdla_core_clk,
  input  logic             nvdla_core_rstn,
  input  logic             in_vld,
  output logic             in_rdy,
  input  logic [width-1:0] in_pd,
  output logic             out_vld,
  input  logic             out_rdy,
  output logic [width-1:0] out_pd
);

  logic [width-1:0] mem [2];
  logic [1:0]       wptr;  // msb is the wrap bit
  logic [1:0]       rptr;
  logic             push;
  logic             pop;

  assign in_rdy  = ~((wptr[1] ^ rptr[1]) & (wptr[0] == rptr[0]));
  assign out_vld = (wptr != rptr);
  assign push    = in_vld & in_rdy;
  assign pop     = out_vld & out_rdy;
  assign out_pd  = mem[rptr[0]];

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wptr <= 2'd0;
      rptr <= 2'd0;
    end else begin
      if (push) wptr <= wptr + 2'd1;
      if (pop)  rptr <= rptr + 2'd1;
    end
  end

  // storage, no reset needed
  always_ff @(posedge nvdla_core_clk) begin
    if (push) begin
      mem[wptr[0]] <= in_pd;
    end
  end

endmodule

`default_nettype wire

// File: source/rbk_rf_wr_seq.sv
`timescale 1ns/1ps
`default_nettype none

`include "rbk_rf_defines.svh"

module rbk_rf_wr_seq (
  input  logic                    nvdla_core_clk,
  input  logic                    nvdla_core_rstn,
  input  rbk_rf_pkg::rbk_mode_e   mode,
  input  rbk_rf_pkg::rbk_prec_e   prec,
  input  logic                    cmd_vld,
  output logic                    cmd_rdy,
  input  rbk_rf_pkg::rbk_wr_cmd_t cmd,
  input  logic                    data_fifo_vld,
  output logic                    data_fifo_rdy,
  input  logic [`RBK_DATA_W-1:0]  data_fifo_pd,
  input  logic                    rf_wr_rdy,
  input  logic                    rf_full,
  output logic                    rf_wr_vld,
  output rbk_rf_pkg::rbk_rf_wr_t  rf_wr
);

  import rbk_rf_pkg::*;

  logic                   m_contract;
  logic                   m_int16;
  logic                   cmd_hold;   // waiting for first command
  logic                   cmd_open;
  logic [`RBK_CNT_W:0]    total_col;  // up to 64 columns
  logic [`RBK_CNT_W-1:0]  total_row;
  logic [`RBK_CNT_W-1:0]  total_colm;
  logic [`RBK_CNT_W-1:0]  ccnt;
  logic [`RBK_CNT_W-1:0]  ccnt_inc;
  logic [`RBK_CNT_W-1:0]  rcnt;
  logic [`RBK_CNT_W-1:0]  rcnt_inc;
  logic                   col_end;
  logic                   row_end;
  logic [`RBK_ADDR_W-1:0] wr_addr;

  assign m_contract = (mode == rbk_mode_contract);
  assign m_int16    = (prec == rbk_prec_int16);

  ////////////////////////////////////////////////////////////////////////////
  // command pop
  assign cmd_rdy = row_end | cmd_hold;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cmd_hold  <= 1'b1;
      cmd_open  <= 1'b0;
      total_col <= '0;
      total_row <= '0;
    end else begin
      if (cmd_hold & cmd_vld) cmd_hold <= 1'b0;
      else if (row_end & ~cmd_vld) cmd_hold <= 1'b1;
      if (cmd_vld & cmd_rdy) begin
        cmd_open  <= 1'b1;
        total_col <= cmd.col_m1 + 1'b1;
        total_row <= cmd.row_m1 + 1'b1;
      end else if (row_end) begin
        cmd_open <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // data beats and counters
  assign data_fifo_rdy = cmd_open & rf_wr_rdy & ~rf_full & data_fifo_vld;
  assign rf_wr_vld     = data_fifo_vld & data_fifo_rdy;

  assign total_colm = total_col[`RBK_CNT_W:1] + total_col[0];  // two columns per addr
  assign ccnt_inc   = ccnt + 1'b1;
  assign rcnt_inc   = rcnt + 1'b1;
  assign col_end    = rf_wr_vld & (ccnt_inc >= total_colm);
  assign row_end    = col_end & (rcnt_inc == total_row);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      ccnt    <= '0;
      rcnt    <= '0;
      wr_addr <= '0;
    end else begin
      if (col_end) ccnt <= '0;
      else if (rf_wr_vld) ccnt <= ccnt_inc;
      if (row_end) rcnt <= '0;
      else if (col_end) rcnt <= rcnt_inc;
      // contract rows sit 4 apart, merge int16 rows 2 apart
      if (row_end) wr_addr <= '0;
      else if (m_contract & col_end) wr_addr <= {rcnt_inc[2:0], 2'b00};
      else if (~m_contract & m_int16 & col_end) wr_addr <= {rcnt_inc[3:0], 1'b0};
      else if (rf_wr_vld) wr_addr <= wr_addr + 1'b1;
    end
  end

  assign rf_wr.addr = wr_addr;
  assign rf_wr.data = data_fifo_pd;
  assign rf_wr.done = row_end;

endmodule

`default_nettype wire

// File: source/rbk_rf_rd_seq.sv
`timescale 1ns/1ps
`default_nettype none

`include "rbk_rf_defines.svh"

module rbk_rf_rd_seq (
  input  logic                    nvdla_core_clk,
  input  logic                    nvdla_core_rstn,
  input  rbk_rf_pkg::rbk_mode_e   mode,
  input  rbk_rf_pkg::rbk_prec_e   prec,
  input  logic                    cmd_vld,
  output logic                    cmd_rdy,
  input  rbk_rf_pkg::rbk_rd_cmd_t cmd,
  input  logic                    rf_rd_rdy,
  input  logic                    rf_nempty,
  output logic                    rf_rd_vld,
  output rbk_rf_pkg::rbk_rf_rd_t  rf_rd
);

  import rbk_rf_pkg::*;

  localparam int half_w = `RBK_MASK_W / 2;
  localparam logic [half_w-1:0] atom_bytes = `RBK_ATOM_BYTES;

  logic                   m_contract;
  logic                   m_int16;
  logic                   cmd_hold;
  logic                   cmd_open;
  logic [`RBK_CNT_W:0]    col_tmp;    // latched command totals
  logic [`RBK_CNT_W:0]    row_tmp;
  logic [`RBK_CNT_W:0]    rd_total_col;
  logic [`RBK_CNT_W:0]    rd_total_row;
  logic [`RBK_CNT_W-1:0]  total_colm;
  logic [`RBK_CNT_W-1:0]  ccnt;
  logic [`RBK_CNT_W-1:0]  ccnt_inc;
  logic [`RBK_CNT_W-1:0]  rcnt;
  logic [`RBK_CNT_W:0]    rcnt_inc;
  logic                   col_end;
  logic                   row_end;
  logic [`RBK_ADDR_W-1:0] rd_addr;
  logic [`RBK_CNT_W:0]    remain_col;
  logic [`RBK_CNT_W:0]    remain_row;
  logic [half_w-1:0]      byte_num;
  logic [`RBK_MASK_W-1:0] contract_mask;
  logic [`RBK_MASK_W-1:0] merge_mask;

  assign m_contract = (mode == rbk_mode_contract);
  assign m_int16    = (prec == rbk_prec_int16);

  ////////////////////////////////////////////////////////////////////////////
  // command pop, one group per command
  assign cmd_rdy = row_end | cmd_hold;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cmd_hold <= 1'b1;
      cmd_open <= 1'b0;
      col_tmp  <= '0;
      row_tmp  <= '0;
    end else begin
      if (cmd_hold & cmd_vld) cmd_hold <= 1'b0;
      else if (row_end & ~cmd_vld) cmd_hold <= 1'b1;
      if (cmd_vld & cmd_rdy) begin
        cmd_open <= 1'b1;
        col_tmp  <= cmd.col_m1 + 1'b1;
        row_tmp  <= cmd.row_m1 + 1'b1;
      end else if (row_end) begin
        cmd_open <= 1'b0;
      end
    end
  end

  // merge reads one row of element columns
  assign rd_total_col = m_contract ? col_tmp : row_tmp;
  assign rd_total_row = m_contract ? row_tmp : (`RBK_CNT_W+1)'(1);

  ////////////////////////////////////////////////////////////////////////////
  // read beats
  assign rf_rd_vld  = rf_rd_rdy & rf_nempty & cmd_open;
  assign total_colm = rd_total_col[`RBK_CNT_W:1] + rd_total_col[0];
  assign ccnt_inc   = ccnt + 1'b1;
  assign rcnt_inc   = rcnt + 1'b1;
  assign col_end    = rf_rd_vld & (ccnt_inc >= total_colm);
  assign row_end    = col_end & (rcnt_inc == rd_total_row);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      ccnt    <= '0;
      rcnt    <= '0;
      rd_addr <= '0;
    end else begin
      if (col_end) ccnt <= '0;
      else if (rf_rd_vld) ccnt <= ccnt_inc;
      if (row_end) rcnt <= '0;
      else if (col_end) rcnt <= rcnt_inc[`RBK_CNT_W-1:0];
      if (row_end) rd_addr <= '0;
      else if (m_contract & col_end) rd_addr <= {rcnt_inc[2:0], 2'b00};
      else if (rf_rd_vld) rd_addr <= rd_addr + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // byte mask, atom0 in the low half
  assign remain_col = col_tmp - {ccnt, 1'b0};
  assign remain_row = row_tmp - {ccnt, 1'b0};
  assign byte_num   = m_int16 ? {col_tmp[half_w-2:0], 1'b0} : col_tmp[half_w-1:0];

  assign contract_mask = (remain_col == 1) ? {{half_w{1'b0}}, atom_bytes}
                                           : {atom_bytes, atom_bytes};
  assign merge_mask    = (remain_row == 1) ? {{half_w{1'b0}}, byte_num}  // odd tail
                                           : {byte_num, byte_num};

  assign rf_rd.addr = rd_addr;
  assign rf_rd.mask = m_contract ? contract_mask : merge_mask;
  assign rf_rd.done = row_end;

endmodule

`default_nettype wire

// File: source/rbk_rf_slot_track.sv
`timescale 1ns/1ps
`default_nettype none

`include "rbk_rf_defines.svh"

module rbk_rf_slot_track (
  input  logic nvdla_core_clk,
  input  logic nvdla_core_rstn,
  input  logic wr_done,
  input  logic rd_done,
  output logic rf_full,
  output logic rf_nempty
);

  logic [`RBK_SLOT_PTR_W-1:0] wptr;  // blocks written
  logic [`RBK_SLOT_PTR_W-1:0] rptr;  // blocks read

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wptr <= '0;
      rptr <= '0;
    end else begin
      if (wr_done) wptr <= wptr + 1'b1;
      if (rd_done) rptr <= rptr + 1'b1;
    end
  end

  // full when only the wrap bit differs
  assign rf_full   = ((wptr ^ rptr) == {1'b1, {(`RBK_SLOT_PTR_W-1){1'b0}}});
  assign rf_nempty = (wptr != rptr);

endmodule

`default_nettype wire

// File: source/rbk_rf_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "rbk_rf_defines.svh"

module rbk_rf_ctrl (
  input  logic                    nvdla_core_clk,
  input  logic                    nvdla_core_rstn,
  input  rbk_rf_pkg::rbk_mode_e   mode,
  input  rbk_rf_pkg::rbk_prec_e   prec,
  input  logic                    wr_cmd_vld,
  output logic                    wr_cmd_rdy,
  input  rbk_rf_pkg::rbk_wr_cmd_t wr_cmd,
  input  logic                    rd_cmd_vld,
  output logic                    rd_cmd_rdy,
  input  rbk_rf_pkg::rbk_rd_cmd_t rd_cmd,
  input  logic                    data_fifo_vld,
  output logic                    data_fifo_rdy,
  input  logic [`RBK_DATA_W-1:0]  data_fifo_pd,
  input  logic                    rf_wr_rdy,
  output logic                    rf_wr_vld,
  output rbk_rf_pkg::rbk_rf_wr_t  rf_wr,
  input  logic                    rf_rd_rdy,
  output logic                    rf_rd_vld,
  output rbk_rf_pkg::rbk_rf_rd_t  rf_rd
);

  import rbk_rf_pkg::*;

  logic        wr_cmd_ovld;
  logic        wr_cmd_ordy;
  rbk_wr_cmd_t wr_cmd_opd;
  logic        rd_cmd_ovld;
  logic        rd_cmd_ordy;
  rbk_rd_cmd_t rd_cmd_opd;
  logic        rf_full;
  logic        rf_nempty;

  ////////////////////////////////////////////////////////////////////////////
  // command FIFOs
  rbk_cmd_fifo #(.width(`RBK_WCMD_W)) u_wr_cmd_fifo (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .in_vld          (wr_cmd_vld),
    .in_rdy          (wr_cmd_rdy),
    .in_pd           (wr_cmd),
    .out_vld         (wr_cmd_ovld),
    .out_rdy         (wr_cmd_ordy),
    .out_pd          (wr_cmd_opd)
  );

  rbk_cmd_fifo #(.width(`RBK_RCMD_W)) u_rd_cmd_fifo (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .in_vld          (rd_cmd_vld),
    .in_rdy          (rd_cmd_rdy),
    .in_pd           (rd_cmd),
    .out_vld         (rd_cmd_ovld),
    .out_rdy         (rd_cmd_ordy),
    .out_pd          (rd_cmd_opd)
  );

  ////////////////////////////////////////////////////////////////////////////
  // write and read sequencers, one block apart
  rbk_rf_wr_seq u_rbk_rf_wr_seq (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .mode            (mode),
    .prec            (prec),
    .cmd_vld         (wr_cmd_ovld),
    .cmd_rdy         (wr_cmd_ordy),
    .cmd             (wr_cmd_opd),
    .data_fifo_vld   (data_fifo_vld),
    .data_fifo_rdy   (data_fifo_rdy),
    .data_fifo_pd    (data_fifo_pd),
    .rf_wr_rdy       (rf_wr_rdy),
    .rf_full         (rf_full),
    .rf_wr_vld       (rf_wr_vld),
    .rf_wr           (rf_wr)
  );

  rbk_rf_rd_seq u_rbk_rf_rd_seq (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .mode            (mode),
    .prec            (prec),
    .cmd_vld         (rd_cmd_ovld),
    .cmd_rdy         (rd_cmd_ordy),
    .cmd             (rd_cmd_opd),
    .rf_rd_rdy       (rf_rd_rdy),
    .rf_nempty       (rf_nempty),
    .rf_rd_vld       (rf_rd_vld),
    .rf_rd           (rf_rd)
  );

  rbk_rf_slot_track u_rbk_rf_slot_track (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .wr_done         (rf_wr.done),  // last write beat
    .rd_done         (rf_rd.done),
    .rf_full         (rf_full),
    .rf_nempty       (rf_nempty)
  );

endmodule

`default_nettype wire

// File: test/rbk_rf_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rbk_rf_defines.svh"

module rbk_rf_ctrl_tb;

  import rbk_rf_pkg::*;

  localparam int num_tests    = 5;
  localparam int blocks       = 3;  // two fill the tracker, third waits
  localparam int hold_cycles  = 8;
  localparam int half_w       = `RBK_MASK_W / 2;

  typedef struct {
    string       name;
    rbk_mode_e   mode;
    rbk_prec_e   prec;
    rbk_wr_cmd_t wr;
    rbk_rd_cmd_t rd;
    int          wr_beats;  // per block
    int          rd_beats;
  } test_row_t;

  logic                   nvdla_core_clk;
  logic                   nvdla_core_rstn;
  rbk_mode_e              mode;
  rbk_prec_e              prec;
  logic                   wr_cmd_vld;
  logic                   wr_cmd_rdy;
  rbk_wr_cmd_t            wr_cmd;
  logic                   rd_cmd_vld;
  logic                   rd_cmd_rdy;
  rbk_rd_cmd_t            rd_cmd;
  logic                   data_fifo_vld;
  logic                   data_fifo_rdy;
  logic [`RBK_DATA_W-1:0] data_fifo_pd;
  logic                   rf_wr_rdy;
  logic                   rf_wr_vld;
  rbk_rf_wr_t             rf_wr;
  logic                   rf_rd_rdy;
  logic                   rf_rd_vld;
  rbk_rf_rd_t             rf_rd;

  test_row_t              tests [num_tests];
  logic [`RBK_ADDR_W-1:0] exp_wr_addr [$];
  logic [`RBK_ADDR_W-1:0] exp_rd_addr [$];
  logic [`RBK_MASK_W-1:0] exp_rd_mask [$];
  logic [31:0]            rng_state;
  string                  cur_name;
  int                     cur_test;
  int                     n_checks;
  int                     n_errors;
  int                     test_errors;
  int                     cycles;
  int                     cycle_limit;

  rbk_rf_ctrl rbk_rf_ctrl_inst (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .mode            (mode),
    .prec            (prec),
    .wr_cmd_vld      (wr_cmd_vld),
    .wr_cmd_rdy      (wr_cmd_rdy),
    .wr_cmd          (wr_cmd),
    .rd_cmd_vld      (rd_cmd_vld),
    .rd_cmd_rdy      (rd_cmd_rdy),
    .rd_cmd          (rd_cmd),
    .data_fifo_vld   (data_fifo_vld),
    .data_fifo_rdy   (data_fifo_rdy),
    .data_fifo_pd    (data_fifo_pd),
    .rf_wr_rdy       (rf_wr_rdy),
    .rf_wr_vld       (rf_wr_vld),
    .rf_wr           (rf_wr),
    .rf_rd_rdy       (rf_rd_rdy),
    .rf_rd_vld       (rf_rd_vld),
    .rf_rd           (rf_rd)
  );

  initial begin
    nvdla_core_clk = 1'b0;
    forever #10 nvdla_core_clk = ~nvdla_core_clk;
  end

  // watchdog
  always @(posedge nvdla_core_clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout after %0d cycles in %s, the DUT stopped making progress",
               cycles, cur_name);
      $display("Simulation FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // each 32-bit word tagged with test, block, beat and word index
  function automatic logic [`RBK_DATA_W-1:0] beat_data(input int blk, input int idx);
    logic [`RBK_DATA_W-1:0] d;
    int                     k;
    for (k = 0; k < `RBK_DATA_W / 32; k++) begin
      d[k*32 +: 32] = {8'(cur_test), 8'(blk), 8'(idx), 8'(k)};
    end
    return d;
  endfunction

  task automatic check_val(input string what, input logic [`RBK_DATA_W-1:0] exp_v,
                           input logic [`RBK_DATA_W-1:0] act_v);
    n_checks++;
    assert (act_v === exp_v) else begin
      n_errors++;
      test_errors++;
      $display("[FAIL] %s %s: expected %0h, actual %0h", cur_name, what, exp_v, act_v);
    end
  endtask

  task automatic add_row(input int i, input string name, input rbk_mode_e m,
                         input rbk_prec_e p, input int wr_row_m1, input int wr_col_m1,
                         input int rd_row_m1, input int rd_col_m1,
                         input int wr_beats, input int rd_beats);
    tests[i].name      = name;
    tests[i].mode      = m;
    tests[i].prec      = p;
    tests[i].wr.row_m1 = wr_row_m1[`RBK_WCMD_W-`RBK_CNT_W-1:0];
    tests[i].wr.col_m1 = wr_col_m1[`RBK_CNT_W-1:0];
    tests[i].rd.row_m1 = rd_row_m1[`RBK_CNT_W-1:0];
    tests[i].rd.col_m1 = rd_col_m1[`RBK_CNT_W-1:0];
    tests[i].wr_beats  = wr_beats;
    tests[i].rd_beats  = rd_beats;
  endtask

  // name, mode, prec, wr row_m1/col_m1, rd row_m1/col_m1, wr beats, rd beats
  task automatic load_table();
    add_row(0, "contract_4x2", rbk_mode_contract, rbk_prec_int8, 1, 3, 1, 3, 4, 4);
    add_row(1, "contract_odd", rbk_mode_contract, rbk_prec_int8, 2, 2, 2, 4, 6, 9);
    add_row(2, "merge_int16", rbk_mode_merge, rbk_prec_int16, 4, 1, 4, 5, 5, 3);
    add_row(3, "merge_int8", rbk_mode_merge, rbk_prec_int8, 2, 5, 7, 20, 9, 4);
    add_row(4, "contract_single", rbk_mode_contract, rbk_prec_int8, 0, 0, 0, 0, 1, 1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model, addresses and masks per beat

  task automatic build_model(input int t);
    int                rows;
    int                cols;
    int                units;
    int                addr;
    int                remain;
    int                bytes;
    int                r;
    int                c;
    logic [half_w-1:0] b;
    logic [half_w-1:0] atom;
    exp_wr_addr.delete();
    exp_rd_addr.delete();
    exp_rd_mask.delete();
    atom  = `RBK_ATOM_BYTES;
    rows  = int'(tests[t].wr.row_m1) + 1;
    units = (int'(tests[t].wr.col_m1) + 2) / 2;  // two columns per address
    for (r = 0; r < rows; r++) begin
      for (c = 0; c < units; c++) begin
        if (tests[t].mode == rbk_mode_contract) addr = 4 * r + c;
        else if (tests[t].prec == rbk_prec_int16) addr = 2 * r + c;
        else addr = r * units + c;
        exp_wr_addr.push_back(addr[`RBK_ADDR_W-1:0]);
      end
    end
    rows = int'(tests[t].rd.row_m1) + 1;
    cols = int'(tests[t].rd.col_m1) + 1;
    if (tests[t].mode == rbk_mode_contract) begin
      units = (cols + 1) / 2;
      for (r = 0; r < rows; r++) begin
        for (c = 0; c < units; c++) begin
          addr   = 4 * r + c;
          remain = cols - 2 * c;
          exp_rd_addr.push_back(addr[`RBK_ADDR_W-1:0]);
          exp_rd_mask.push_back((remain == 1) ? {{half_w{1'b0}}, atom} : {atom, atom});
        end
      end
    end else begin
      bytes = (tests[t].prec == rbk_prec_int16) ? 2 * cols : cols;
      b     = bytes[half_w-1:0];
      for (c = 0; c < (rows + 1) / 2; c++) begin  // one row, element columns
        remain = rows - 2 * c;
        exp_rd_addr.push_back(c[`RBK_ADDR_W-1:0]);
        exp_rd_mask.push_back((remain == 1) ? {{half_w{1'b0}}, b} : {b, b});
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // drivers

  task automatic push_wr_cmd(input rbk_wr_cmd_t c);
    @(posedge nvdla_core_clk);
    wr_cmd_vld <= 1'b1;
    wr_cmd     <= c;
    @(negedge nvdla_core_clk);
    while (!wr_cmd_rdy) @(negedge nvdla_core_clk);
    @(posedge nvdla_core_clk);
    wr_cmd_vld <= 1'b0;
  endtask

  task automatic push_rd_cmd(input rbk_rd_cmd_t c);
    @(posedge nvdla_core_clk);
    rd_cmd_vld <= 1'b1;
    rd_cmd     <= c;
    @(negedge nvdla_core_clk);
    while (!rd_cmd_rdy) @(negedge nvdla_core_clk);
    @(posedge nvdla_core_clk);
    rd_cmd_vld <= 1'b0;
  endtask

  task automatic write_block(input int blk);
    int    idx;
    logic  done_seen;
    logic  stall;
    string tag;
    idx       = 0;
    done_seen = 1'b0;
    tag       = $sformatf("blk%0d", blk);
    while (!done_seen) begin
      @(posedge nvdla_core_clk);
      rng_state = xorshift32(rng_state);
      stall     = (rng_state[1:0] == 2'b00);  // stall one cycle in four
      data_fifo_vld <= 1'b1;
      data_fifo_pd  <= beat_data(blk, idx);
      rf_wr_rdy     <= !stall;
      @(negedge nvdla_core_clk);
      // command open and a slot free, so only the stall holds data back
      check_val({tag, " data_fifo_rdy"}, !stall, data_fifo_rdy);
      check_val({tag, " rf_wr_vld"}, !stall, rf_wr_vld);
      if (rf_wr_vld) begin
        if (idx < exp_wr_addr.size()) check_val({tag, " wr addr"}, exp_wr_addr[idx], rf_wr.addr);
        check_val({tag, " wr data"}, beat_data(blk, idx), rf_wr.data);
        check_val({tag, " wr done"}, idx == exp_wr_addr.size() - 1, rf_wr.done);
        done_seen = rf_wr.done;
        idx++;
      end
    end
    @(posedge nvdla_core_clk);
    data_fifo_vld <= 1'b0;
    rf_wr_rdy     <= 1'b0;
    check_val({tag, " wr beats"}, tests[cur_test].wr_beats, idx);
  endtask

  task automatic read_block(input int blk);
    int    idx;
    logic  done_seen;
    logic  stall;
    string tag;
    idx       = 0;
    done_seen = 1'b0;
    tag       = $sformatf("blk%0d", blk);
    while (!done_seen) begin
      @(posedge nvdla_core_clk);
      rng_state = xorshift32(rng_state);
      stall     = (rng_state[1:0] == 2'b00);
      rf_rd_rdy <= !stall;
      @(negedge nvdla_core_clk);
      check_val({tag, " rf_rd_vld"}, !stall, rf_rd_vld);  // block stored, command open
      if (rf_rd_vld) begin
        if (idx < exp_rd_addr.size()) begin
          check_val({tag, " rd addr"}, exp_rd_addr[idx], rf_rd.addr);
          check_val({tag, " rd mask"}, exp_rd_mask[idx], rf_rd.mask);
        end
        check_val({tag, " rd done"}, idx == exp_rd_addr.size() - 1, rf_rd.done);
        done_seen = rf_rd.done;
        idx++;
      end
    end
    @(posedge nvdla_core_clk);
    rf_rd_rdy <= 1'b0;
    check_val({tag, " rd beats"}, tests[cur_test].rd_beats, idx);
  endtask

  // read command open but nothing written
  task automatic check_empty_hold();
    int i;
    for (i = 0; i < hold_cycles; i++) begin
      @(posedge nvdla_core_clk);
      rf_rd_rdy <= 1'b1;
      @(negedge nvdla_core_clk);
      check_val("empty rf_rd_vld", 0, rf_rd_vld);
    end
    @(posedge nvdla_core_clk);
    rf_rd_rdy <= 1'b0;
  endtask

  // two blocks stored, third write command open
  task automatic check_full_hold();
    int i;
    for (i = 0; i < hold_cycles; i++) begin
      @(posedge nvdla_core_clk);
      data_fifo_vld <= 1'b1;
      data_fifo_pd  <= beat_data(2, 0);
      rf_wr_rdy     <= 1'b1;
      @(negedge nvdla_core_clk);
      check_val("full data_fifo_rdy", 0, data_fifo_rdy);
      check_val("full rf_wr_vld", 0, rf_wr_vld);
    end
    @(posedge nvdla_core_clk);
    data_fifo_vld <= 1'b0;
    rf_wr_rdy     <= 1'b0;
  endtask

  task automatic run_test(input int t);
    int blk;
    cur_test    = t;
    cur_name    = tests[t].name;
    test_errors = 0;
    build_model(t);
    @(posedge nvdla_core_clk);
    mode <= tests[t].mode;
    prec <= tests[t].prec;
    for (blk = 0; blk < blocks; blk++) push_rd_cmd(tests[t].rd);
    check_empty_hold();
    for (blk = 0; blk < blocks; blk++) push_wr_cmd(tests[t].wr);
    write_block(0);
    write_block(1);
    check_full_hold();
    read_block(0);
    write_block(2);  // slot freed by the first read
    read_block(1);
    read_block(2);
    $display("test %-16s errors %0d", cur_name, test_errors);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    int t;
    int total_beats;
    nvdla_core_rstn <= 1'b0;
    mode            <= rbk_mode_contract;
    prec            <= rbk_prec_int8;
    wr_cmd_vld      <= 1'b0;
    wr_cmd          <= '0;
    rd_cmd_vld      <= 1'b0;
    rd_cmd          <= '0;
    data_fifo_vld   <= 1'b0;
    data_fifo_pd    <= '0;
    rf_wr_rdy       <= 1'b0;
    rf_rd_rdy       <= 1'b0;
    rng_state   = 32'hefbe_c7e0;
    cur_name    = "reset";
    cur_test    = 0;
    n_checks    = 0;
    n_errors    = 0;
    test_errors = 0;
    cycles      = 0;
    load_table();
    total_beats = 0;
    for (t = 0; t < num_tests; t++) total_beats += tests[t].wr_beats + tests[t].rd_beats;
    cycle_limit = 8 * total_beats + 400;
    repeat (16) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;
    @(negedge nvdla_core_clk);
    check_val("wr_cmd_rdy", 1, wr_cmd_rdy);
    check_val("rd_cmd_rdy", 1, rd_cmd_rdy);
    check_val("data_fifo_rdy", 0, data_fifo_rdy);
    check_val("rf_wr_vld", 0, rf_wr_vld);
    check_val("rf_rd_vld", 0, rf_rd_vld);
    $display("test %-16s errors %0d", cur_name, test_errors);
    for (t = 0; t < num_tests; t++) run_test(t);
    $display("tests %0d, checks %0d, errors %0d", num_tests + 1, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+include
source/rbk_rf_pkg.sv
source/rbk_cmd_fifo.sv
source/rbk_rf_wr_seq.sv
source/rbk_rf_rd_seq.sv
source/rbk_rf_slot_track.sv
source/rbk_rf_ctrl.sv
test/rbk_rf_ctrl_tb.sv

// File: Makefile
# Verilator flow for the rubik register-file sequencer testbench

VERILATOR ?= verilator
TOP       ?= rbk_rf_ctrl_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation PASSED
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no pass line found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
